/* sim.f */
+incdir+testbench
source/rv_isa_pkg.sv
source/rv_bus_pkg.sv
source/rv_regfile.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_bus_ctrl.sv
source/rv_exec_core.sv
testbench/tb_exec_core.sv

/* Makefile */
# Verilator simulation of the RV32I execution unit

VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_ref_model.svh */
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// Shadow copy of x0 to x31, x0 stays zero
rv_isa_pkg::word_t shadow [0:rv_isa_pkg::num_regs-1];

// Register update as the DUT should see it, x0 discards
function automatic void shadow_write(input rv_isa_pkg::reg_idx_t idx,
                                     input rv_isa_pkg::word_t data);
  if (idx != '0) begin
    shadow[idx] = data;
  end
endfunction

//************************************************************
// Reference execution of one instruction word
//************************************************************
// Returns 1 for a supported word, res holds the value for rd
function automatic logic ref_exec(input rv_isa_pkg::word_t iw, output rv_isa_pkg::word_t res);
  logic [6:0]        opcode;
  logic [2:0]        f3;
  logic [6:0]        f7;
  logic              is_r;
  logic              legal;
  rv_isa_pkg::word_t a;
  rv_isa_pkg::word_t b;
  opcode = iw[6:0];
  f3     = iw[14:12];
  f7     = iw[31:25];
  is_r   = (opcode == rv_isa_pkg::op_reg);
  a      = shadow[iw[19:15]];
  // Second operand is rs2 or the sign extended immediate
  b      = is_r ? shadow[iw[24:20]] : {{20{iw[31]}}, iw[31:20]};
  // Only add and srl take the alternate funct7 in the R group
  if (is_r) begin
    legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
  end else if (opcode == rv_isa_pkg::op_imm) begin
    // Immediate shifts keep the funct7 rules of the R group
    if (f3 == 3'd1) begin
      legal = (f7 == 7'h00);
    end else if (f3 == 3'd5) begin
      legal = (f7 == 7'h00) || (f7 == 7'h20);
    end else begin
      legal = 1'b1;
    end
  end else begin
    legal = 1'b0;
  end
  case (f3)
    3'd0:    res = (is_r && iw[30]) ? a - b : a + b;
    3'd1:    res = a << b[4:0];
    3'd2:    res = {31'b0, $signed(a) < $signed(b)};
    3'd3:    res = {31'b0, a < b};
    3'd4:    res = a ^ b;
    3'd5:    res = iw[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    res = a | b;
    default: res = a & b;
  endcase
  return legal;
endfunction

`endif

/* testbench/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

  localparam int timeout_cycles = 20;

  // One expected response, data only compared on reads
  typedef struct packed {
    logic              ack;
    logic              err;
    logic              has_data;
    rv_isa_pkg::word_t data;
  } exp_rsp_t;

  logic                clk;
  logic                reset;
  rv_bus_pkg::wb_req_t req;
  rv_bus_pkg::wb_rsp_t rsp;

  logic [31:0] lfsr_state;
  exp_rsp_t    exp_q [$];

  `include "tb_ref_model.svh"

  rv_exec_core i_dut (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .rsp   (rsp)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //**********************************************************
  // Failure, compares and random bits
  //**********************************************************
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_word(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t expected,
                            input string what);
    if (got !== expected) begin
      stop_with_failure($sformatf("error at %0t: %s is 0x%08h, expected 0x%08h",
                                  $time, what, got, expected));
    end
  endtask

  task automatic check_rsp(input rv_bus_pkg::wb_rsp_t got, input logic exp_ack,
                           input logic exp_err);
    if ((got.ack !== exp_ack) || (got.err !== exp_err)) begin
      stop_with_failure($sformatf("error at %0t: ack/err is %b/%b, expected %b/%b",
                                  $time, got.ack, got.err, exp_ack, exp_err));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic void expect_rsp(input logic ack, input logic err, input logic has_data,
                                     input rv_isa_pkg::word_t data);
    exp_rsp_t e;
    e.ack      = ack;
    e.err      = err;
    e.has_data = has_data;
    e.data     = data;
    exp_q.push_back(e);
  endfunction

  // Every response must match the oldest outstanding expectation
  always @(negedge clk) begin
    exp_rsp_t e;
    if (rsp.ack || rsp.err) begin
      if (exp_q.size() == 0) begin
        stop_with_failure($sformatf("response at %0t with no request outstanding", $time));
      end else begin
        e = exp_q.pop_front();
        check_rsp(rsp, e.ack, e.err);
        if (e.has_data) begin
          check_word(rsp.dat_r, e.data, "dat_r");
        end
      end
    end
  end

  //**********************************************************
  // Bus tasks
  //**********************************************************
  // Hold keeps stb up for extra cycles after the response
  task automatic bus_cycle(input logic we, input rv_bus_pkg::wb_adr_t adr,
                           input rv_isa_pkg::word_t data, input int hold);
    int   n;
    logic seen;
    @(negedge clk);
    req.cyc   = 1'b1;
    req.stb   = 1'b1;
    req.we    = we;
    req.adr   = adr;
    req.dat_w = data;
    seen      = 1'b0;
    n         = 0;
    while (!seen && (n < timeout_cycles)) begin
      @(negedge clk);
      seen = rsp.ack || rsp.err;
      n++;
    end
    if (!seen) begin
      stop_with_failure($sformatf("bus cycle to address %0d got no ack or err in %0d cycles",
                                  adr, timeout_cycles));
    end
    repeat (hold) @(negedge clk);
    req = '0;
  endtask

  function automatic rv_bus_pkg::wb_adr_t reg_adr(input rv_isa_pkg::reg_idx_t idx);
    return rv_bus_pkg::adr_reg_base + rv_bus_pkg::wb_adr_t'(idx);
  endfunction

  task automatic reg_write(input rv_isa_pkg::reg_idx_t idx, input rv_isa_pkg::word_t data,
                           input int hold);
    expect_rsp(1'b1, 1'b0, 1'b0, '0);
    bus_cycle(1'b1, reg_adr(idx), data, hold);
    shadow_write(idx, data);
  endtask

  task automatic reg_read(input rv_isa_pkg::reg_idx_t idx);
    expect_rsp(1'b1, 1'b0, 1'b1, shadow[idx]);
    bus_cycle(1'b0, reg_adr(idx), '0, 0);
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
      reg_read(rv_isa_pkg::reg_idx_t'(i));
    end
  endtask

  // Execute, then read rd back
  task automatic exec_instr(input rv_isa_pkg::word_t iw);
    rv_isa_pkg::word_t res;
    logic              legal;
    legal = ref_exec(iw, res);
    expect_rsp(legal, !legal, 1'b0, '0);
    bus_cycle(1'b1, rv_bus_pkg::adr_instr, iw, 0);
    if (legal) begin
      shadow_write(iw[11:7], res);
    end
    reg_read(iw[11:7]);
  endtask

  // Word known to be unsupported, must give err
  task automatic exec_illegal(input rv_isa_pkg::word_t iw, input int hold);
    expect_rsp(1'b0, 1'b1, 1'b0, '0);
    bus_cycle(1'b1, rv_bus_pkg::adr_instr, iw, hold);
  endtask

  task automatic bus_read_err(input rv_bus_pkg::wb_adr_t adr, input int hold);
    expect_rsp(1'b0, 1'b1, 1'b0, '0);
    bus_cycle(1'b0, adr, '0, hold);
  endtask

  //**********************************************************
  // Stimulus
  //**********************************************************
  initial begin
    rv_isa_pkg::word_t    iw;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    logic [2:0]           f3;
    logic [6:0]           f7;
    logic [11:0]          imm;
    clk        = 1'b0;
    reset      = 1'b1;
    req        = '0;
    lfsr_state = 32'h7c7d_29db;
    shadow[0]  = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    // Direct loads of x1 to x31, then read back
    for (int i = 1; i < rv_isa_pkg::num_regs; i++) begin
      reg_write(rv_isa_pkg::reg_idx_t'(i), take_bits(32), 0);
    end
    read_all_regs();

    // x0 write is acked and dropped
    reg_write('0, take_bits(32), 0);
    reg_read('0);

    // R group, f3 walks all codes, bit 3 of i picks sub and sra
    for (int i = 0; i < 80; i++) begin
      f3  = 3'(i);
      f7  = (((f3 == 3'd0) || (f3 == 3'd5)) && i[3]) ? 7'h20 : 7'h00;
      rd  = rv_isa_pkg::reg_idx_t'(take_bits(5));
      rs1 = rv_isa_pkg::reg_idx_t'(take_bits(5));
      rs2 = rv_isa_pkg::reg_idx_t'(take_bits(5));
      if ((i % 20) == 9) begin
        rd = '0;
      end
      if ((i % 20) == 13) begin
        rs1 = '0;
      end
      iw = {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg};
      exec_instr(iw);
    end

    // I group, random immediates, shifts built from the low five bits
    for (int i = 0; i < 80; i++) begin
      f3  = 3'(i);
      rd  = rv_isa_pkg::reg_idx_t'(take_bits(5));
      rs1 = rv_isa_pkg::reg_idx_t'(take_bits(5));
      imm = 12'(take_bits(12));
      if (f3 == 3'd1) begin
        imm = {7'h00, imm[4:0]};
      end else if (f3 == 3'd5) begin
        imm = {1'b0, i[3], 5'h00, imm[4:0]};
      end
      iw = {imm, rs1, f3, rd, rv_isa_pkg::op_imm};
      exec_instr(iw);
    end

    // Foreign opcodes, bit 2 flip turns OP and OP-IMM into LUI and AUIPC
    for (int i = 0; i < 12; i++) begin
      iw = take_bits(32);
      if ((iw[6:0] == rv_isa_pkg::op_reg) || (iw[6:0] == rv_isa_pkg::op_imm)) begin
        iw[2] = ~iw[2];
      end
      exec_illegal(iw, 0);
    end
    // Bad funct7 on add, srl, sll and on immediate shifts
    exec_illegal({7'h01, 5'd3, 5'd4, 3'd0, 5'd5, rv_isa_pkg::op_reg}, 0);
    exec_illegal({7'h40, 5'd3, 5'd4, 3'd5, 5'd6, rv_isa_pkg::op_reg}, 0);
    exec_illegal({7'h20, 5'd3, 5'd4, 3'd1, 5'd7, rv_isa_pkg::op_reg}, 0);
    exec_illegal({7'h10, 5'd3, 5'd4, 3'd1, 5'd8, rv_isa_pkg::op_imm}, 0);
    exec_illegal({7'h60, 5'd3, 5'd4, 3'd5, 5'd9, rv_isa_pkg::op_imm}, 0);
    read_all_regs();

    // Held strobe must give one response only
    reg_write(5'd5, take_bits(32), 4);
    reg_read(5'd5);
    exec_illegal({7'h01, 5'd1, 5'd2, 3'd0, 5'd3, rv_isa_pkg::op_reg}, 3);
    bus_read_err(rv_bus_pkg::adr_instr, 3);
    bus_read_err(7'd1, 0);
    bus_read_err(7'd64, 0);
    bus_read_err(7'd127, 2);
    read_all_regs();

    // Let the monitor take the last response
    @(negedge clk);
    if (exp_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d expected responses never arrived", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

/* source/rv_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core (
  input  logic                clk,
  input  logic                reset,
  input  rv_bus_pkg::wb_req_t req,
  output rv_bus_pkg::wb_rsp_t rsp
);

  rv_isa_pkg::instr_u    instr;
  rv_isa_pkg::decoded_t  dec;
  rv_isa_pkg::reg_idx_t  sel_a;
  rv_isa_pkg::reg_idx_t  sel_b;
  rv_isa_pkg::word_t     port_a;
  rv_isa_pkg::word_t     port_b;
  rv_isa_pkg::word_t     alu_result;
  rv_isa_pkg::rf_write_t wr;

  // Bus side, owns all sequencing
  rv_bus_ctrl i_bus_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .rsp        (rsp),
    .instr      (instr),
    .dec        (dec),
    .sel_a      (sel_a),
    .sel_b      (sel_b),
    .port_a     (port_a),
    .alu_result (alu_result),
    .wr         (wr)
  );

  rv_decoder i_decoder (
    .instr (instr),
    .dec   (dec)
  );

  rv_regfile i_regfile (
    .clk    (clk),
    .sel_a  (sel_a),
    .sel_b  (sel_b),
    .wr     (wr),
    .port_a (port_a),
    .port_b (port_b)
  );

  // Second operand is rs2 or the immediate
  rv_alu i_alu (
    .op     (dec.alu_op),
    .a      (port_a),
    .b      (dec.use_imm ? dec.imm : port_b),
    .result (alu_result)
  );

endmodule

`default_nettype wire

/* source/rv_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_bus_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_bus_pkg::wb_req_t   req,
  output rv_bus_pkg::wb_rsp_t   rsp,
  output rv_isa_pkg::instr_u    instr,
  input  rv_isa_pkg::decoded_t  dec,
  output rv_isa_pkg::reg_idx_t  sel_a,
  output rv_isa_pkg::reg_idx_t  sel_b,
  input  rv_isa_pkg::word_t     port_a,
  input  rv_isa_pkg::word_t     alu_result,
  output rv_isa_pkg::rf_write_t wr
);

  rv_bus_pkg::wb_adr_t  reg_off;
  rv_isa_pkg::reg_idx_t bus_idx;
  logic                 is_instr;
  logic                 is_reg;
  logic                 req_valid;
  logic                 do_exec;
  logic                 do_load;
  logic                 do_read;
  logic                 ack_d;
  logic                 err_d;
  logic                 done_q;
  logic                 ack_q;
  logic                 err_q;
  rv_isa_pkg::word_t    dat_q;

  //**********************************************************
  // Address decode
  //**********************************************************
  assign reg_off  = req.adr - rv_bus_pkg::adr_reg_base;
  assign bus_idx  = rv_isa_pkg::reg_idx_t'(reg_off);
  assign is_instr = (req.adr == rv_bus_pkg::adr_instr);
  assign is_reg   = (req.adr >= rv_bus_pkg::adr_reg_base) &&
                    (reg_off < rv_isa_pkg::num_regs);

  // New request only once per strobe
  assign req_valid = req.cyc && req.stb && !done_q;

  assign do_exec = req_valid && req.we && is_instr;
  assign do_load = req_valid && req.we && is_reg;
  assign do_read = req_valid && !req.we && is_reg;

  // Illegal instructions, reads of the instruction port and holes give err
  assign ack_d = (do_exec && dec.legal) || do_load || do_read;
  assign err_d = (do_exec && !dec.legal) ||
                 (req_valid && !is_reg && !(req.we && is_instr));

  // Datapath steering
  assign instr = req.dat_w;
  assign sel_a = do_read ? bus_idx : dec.rs1;
  assign sel_b = dec.rs2;

  // Write lands on the same edge that raises ack
  assign wr.en   = (do_exec && dec.legal) || do_load;
  assign wr.addr = is_instr ? dec.rd : bus_idx;
  assign wr.data = is_instr ? alu_result : req.dat_w;

  //**********************************************************
  // Response registers
  //**********************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q  <= ack_d;
      err_q  <= err_d;
      // Held until the master drops stb
      done_q <= req.cyc && req.stb && (done_q || ack_d || err_d);
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk) begin
    if (do_read) begin
      dat_q <= port_a;
    end
  end

  assign rsp.ack   = ack_q;
  assign rsp.err   = err_q;
  assign rsp.dat_r = dat_q;

  a_ack_err_excl : assert property (
    @(posedge clk) disable iff (reset) !(rsp.ack && rsp.err)
  ) else $error("ack and err high together");

  // Response only for a strobe seen while no response was up
  a_rsp_needs_req : assert property (
    @(posedge clk) disable iff (reset)
      (rsp.ack || rsp.err) |-> $past(req.cyc && req.stb && !(rsp.ack || rsp.err))
  ) else $error("response without a fresh request on the previous edge");

endmodule

`default_nettype wire

/* source/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_isa_pkg::alu_op_e op,
  input  rv_isa_pkg::word_t   a,
  input  rv_isa_pkg::word_t   b,
  output rv_isa_pkg::word_t   result
);

  // Shift amount from the low five bits only
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_isa_pkg::alu_add:  result = a + b;
      rv_isa_pkg::alu_sub:  result = a - b;
      rv_isa_pkg::alu_sll:  result = a << shamt;
      // Compares return 0 or 1
      rv_isa_pkg::alu_slt:  result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_signed};
      rv_isa_pkg::alu_sltu: result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_unsigned};
      rv_isa_pkg::alu_xor:  result = a ^ b;
      rv_isa_pkg::alu_srl:  result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      rv_isa_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
      rv_isa_pkg::alu_or:   result = a | b;
      rv_isa_pkg::alu_and:  result = a & b;
      default:              result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_isa_pkg::instr_u   instr,
  output rv_isa_pkg::decoded_t dec
);

  always_comb begin
    // Register fields sit at the same bits in both formats
    dec.rs1     = instr.r_fields.rs1;
    dec.rs2     = instr.r_fields.rs2;
    dec.rd      = instr.r_fields.rd;
    // Sign extended I immediate
    dec.imm     = {{(rv_isa_pkg::xlen-12){instr.i_fields.imm12[11]}}, instr.i_fields.imm12};
    dec.alu_op  = rv_isa_pkg::alu_add;
    dec.use_imm = 1'b0;
    dec.legal   = 1'b0;

    case (instr.r_fields.opcode)
      //******************************************************
      // Register-register group
      //******************************************************
      rv_isa_pkg::op_reg: begin
        case (instr.r_fields.funct3)
          3'b000: begin
            // add or sub by funct7 bit 5
            dec.alu_op = instr.r_fields.funct7[5] ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
            dec.legal  = (instr.r_fields.funct7 == rv_isa_pkg::funct7_zero) ||
                         (instr.r_fields.funct7 == rv_isa_pkg::funct7_alt);
          end
          3'b101: begin
            // srl or sra
            dec.alu_op = instr.r_fields.funct7[5] ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
            dec.legal  = (instr.r_fields.funct7 == rv_isa_pkg::funct7_zero) ||
                         (instr.r_fields.funct7 == rv_isa_pkg::funct7_alt);
          end
          default: begin
            case (instr.r_fields.funct3)
              3'b001:  dec.alu_op = rv_isa_pkg::alu_sll;
              3'b010:  dec.alu_op = rv_isa_pkg::alu_slt;
              3'b011:  dec.alu_op = rv_isa_pkg::alu_sltu;
              3'b100:  dec.alu_op = rv_isa_pkg::alu_xor;
              3'b110:  dec.alu_op = rv_isa_pkg::alu_or;
              default: dec.alu_op = rv_isa_pkg::alu_and;
            endcase
            // Remaining ops allow only a zero funct7
            dec.legal = (instr.r_fields.funct7 == rv_isa_pkg::funct7_zero);
          end
        endcase
      end

      //******************************************************
      // Register-immediate group
      //******************************************************
      rv_isa_pkg::op_imm: begin
        dec.use_imm = 1'b1;
        dec.legal   = 1'b1;
        case (instr.i_fields.funct3)
          3'b000: dec.alu_op = rv_isa_pkg::alu_add;
          3'b010: dec.alu_op = rv_isa_pkg::alu_slt;
          3'b011: dec.alu_op = rv_isa_pkg::alu_sltu;
          3'b100: dec.alu_op = rv_isa_pkg::alu_xor;
          3'b110: dec.alu_op = rv_isa_pkg::alu_or;
          3'b111: dec.alu_op = rv_isa_pkg::alu_and;
          3'b001: begin
            // slli, upper seven bits must be zero
            dec.alu_op = rv_isa_pkg::alu_sll;
            dec.legal  = (instr.i_fields.imm12[11:5] == 7'b0);
          end
          default: begin
            // srli or srai picked by imm bit 10
            dec.alu_op = instr.i_fields.imm12[10] ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
            dec.legal  = ({instr.i_fields.imm12[11], instr.i_fields.imm12[9:5]} == 6'b0);
          end
        endcase
      end

      // Anything else is rejected
      default: dec.legal = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                 clk,
  input  rv_isa_pkg::reg_idx_t sel_a,
  input  rv_isa_pkg::reg_idx_t sel_b,
  input  rv_isa_pkg::rf_write_t wr,
  output rv_isa_pkg::word_t    port_a,
  output rv_isa_pkg::word_t    port_b
);

  //**********************************************************
  // Storage
  //**********************************************************
  // Only x1 to x31 exist, x0 is a constant
  rv_isa_pkg::word_t regs [1:rv_isa_pkg::num_regs-1];

  // Write port
  always_ff @(posedge clk) begin
    if (wr.en && (wr.addr != '0)) begin
      regs[wr.addr] <= wr.data;
    end
  end

  //**********************************************************
  // Read ports
  //**********************************************************
  // Combinational, index 0 forced to zero
  always_comb begin
    if (sel_a == '0) begin
      port_a = '0;
    end else begin
      port_a = regs[sel_a];
    end
  end

  always_comb begin
    if (sel_b == '0) begin
      port_b = '0;
    end else begin
      port_b = regs[sel_b];
    end
  end

  // A discarded x0 write leaves the register seen on port_a as it was
  a_x0_write_dropped : assert property (
    @(posedge clk) (wr.en && (wr.addr == '0)) |=>
      ((sel_a != $past(sel_a)) || (port_a == $past(port_a)))
  ) else $error("write to x0 changed the register read on port_a");

endmodule

`default_nettype wire

/* source/rv_bus_pkg.sv */
`default_nettype none

package rv_bus_pkg;

  // Word address width of the slave port
  localparam int adr_w = 7;

  typedef logic [adr_w-1:0] wb_adr_t;

  //**********************************************************
  // Address map
  //**********************************************************
  // Instruction port, write only
  localparam wb_adr_t adr_instr    = 7'd0;
  // x0 at 32 up to x31 at 63
  localparam wb_adr_t adr_reg_base = 7'd32;

  // Host to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    wb_adr_t           adr;
    rv_isa_pkg::word_t dat_w;
  } wb_req_t;

  // Slave to host
  typedef struct packed {
    logic              ack;
    logic              err;
    rv_isa_pkg::word_t dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire

/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // Data width and register count fixed by RV32I
  localparam int xlen     = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0]             word_t;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  // Major opcodes handled by the unit
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;

  // funct7 values, alt selects sub and sra
  localparam logic [6:0] funct7_zero = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  //**********************************************************
  // Instruction word, two views of the same 32 bits
  //**********************************************************
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } instr_u;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // Decoder output
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    alu_op_e  alu_op;
    logic     use_imm;
    word_t    imm;
    logic     legal;
  } decoded_t;

  // Register file write request
  typedef struct packed {
    logic     en;
    reg_idx_t addr;
    word_t    data;
  } rf_write_t;

endpackage

`default_nettype wire
